//--- common/ss_pkg.sv
// sensitivity search shared types
package ss_pkg;

    // --------------------
    // widths and limits
    // --------------------

    // number of independent tuning fields
    localparam int VAR_NUM = 4;

    localparam int FIELD_WIDTH = 4;
    localparam int TUNE_WIDTH = VAR_NUM * FIELD_WIDTH;

    // measured cost from the analog side
    localparam int ANA_WIDTH = 8;

    // evaluation budget and counter
    localparam int ITER_WIDTH = 11;

    // neighbour index runs 0 .. 2*VAR_NUM
    localparam int NBR_WIDTH = 4;

    // upper saturation point of one field
    localparam logic [FIELD_WIDTH-1:0] FIELD_MAX = FIELD_WIDTH'(2 ** FIELD_WIDTH - 1);

    // --------------------
    // data types
    // --------------------

    // flat word at the ports, field array inside the neighbour generator
    typedef union packed {
        logic [TUNE_WIDTH-1:0]                  flat;
        logic [VAR_NUM-1:0][FIELD_WIDTH-1:0]    field;
    } tune_word_t;

    // lower cost is better
    typedef logic [ANA_WIDTH-1:0] ana_t;

    // --------------------
    // control
    // --------------------

    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        REQUEST_INIT = 3'd1,
        ACTIVATE_SS  = 3'd2,
        WAIT_CF      = 3'd3,
        RECEIVE      = 3'd4,
        JUDGE_NEXT   = 3'd5,
        IMPROVEMENT  = 3'd6,
        DONE         = 3'd7
    } ss_state_e;

    // strobes from the FSM to the datapath blocks
    typedef struct packed {
        logic load_start;
        logic init_best;
        logic record_nbr;
        logic inc_cnt;
        logic rst_round;
        logic move_center;
        logic req_tune;
        logic busy;
    } ss_ctrl_t;

    // flags back to the FSM
    typedef struct packed {
        logic reach_max_iter;
        logic chk_all_neighbor;
        logic found_local_min;
    } ss_status_t;

endpackage

//--- logic/ss_tuner_top.sv
// sensitivity search tuner top level
`timescale 1ns/1ns

module ss_tuner_top (
    input  logic                          CLK,
    input  logic                          RST_N,
    input  logic                          start,
    input  ss_pkg::tune_word_t            init_tune,
    input  logic [ss_pkg::ITER_WIDTH-1:0] max_iter,
    output logic                          tune_ready,
    output ss_pkg::tune_word_t            tune_bits,
    input  logic                          nxt,
    input  ss_pkg::ana_t                  ana_val,
    output logic                          done,
    output ss_pkg::tune_word_t            best_tune,
    output ss_pkg::ana_t                  best_cost,
    output logic [ss_pkg::ITER_WIDTH-1:0] eval_cnt
);

    ss_pkg::ss_ctrl_t   ctrl;
    ss_pkg::ss_status_t status;
    ss_pkg::tune_word_t win_tune;

    logic [ss_pkg::NBR_WIDTH-1:0] nbr_idx;
    logic                         reach_max_iter;
    logic                         chk_all_neighbor;
    logic                         found_local_min;

    // flags gathered for the FSM
    assign status.reach_max_iter   = reach_max_iter;
    assign status.chk_all_neighbor = chk_all_neighbor;
    assign status.found_local_min  = found_local_min;

    ss_ctrl_fsm ss_ctrl_fsm_inst (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .start      (start),
        .nxt        (nxt),
        .status     (status),
        .ctrl       (ctrl),
        .tune_ready (tune_ready),
        .done       (done)
    );

    ss_iter_counter ss_iter_counter_inst (
        .CLK              (CLK),
        .RST_N            (RST_N),
        .ctrl             (ctrl),
        .max_iter         (max_iter),
        .nbr_idx          (nbr_idx),
        .eval_cnt         (eval_cnt),
        .reach_max_iter   (reach_max_iter),
        .chk_all_neighbor (chk_all_neighbor)
    );

    ss_neighbor_gen ss_neighbor_gen_inst (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .ctrl      (ctrl),
        .init_tune (init_tune),
        .nbr_idx   (nbr_idx),
        .win_tune  (win_tune),
        .tune_bits (tune_bits)
    );

    ss_best_tracker ss_best_tracker_inst (
        .CLK             (CLK),
        .RST_N           (RST_N),
        .ctrl            (ctrl),
        .tune_bits       (tune_bits),
        .ana_val         (ana_val),
        .best_tune       (best_tune),
        .best_cost       (best_cost),
        .win_tune        (win_tune),
        .found_local_min (found_local_min)
    );

endmodule

//--- run.sh
#!/bin/sh
# build and run the tuner testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module ss_tuner_tb -o ss_tuner_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/ss_tuner_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0

//--- search/ss_best_tracker.sv
// best cost and round winner tracking
`timescale 1ns/1ns

module ss_best_tracker (
    input  logic               CLK,
    input  logic               RST_N,
    input  ss_pkg::ss_ctrl_t   ctrl,
    input  ss_pkg::tune_word_t tune_bits,
    input  ss_pkg::ana_t       ana_val,
    output ss_pkg::tune_word_t best_tune,
    output ss_pkg::ana_t       best_cost,
    output ss_pkg::tune_word_t win_tune,
    output logic               found_local_min
);

    // cost sampled every cycle, holds the nxt value during RECEIVE
    ss_pkg::ana_t ana_q;

    ss_pkg::ana_t win_cost;
    logic         win_valid;
    logic         better;

    always_ff @(posedge CLK) begin
        ana_q <= ana_val;
    end

    // strict improvement over the best and over any earlier winner
    assign better = (ana_q < best_cost) && (!win_valid || (ana_q < win_cost));

    // --------------------
    // best point
    // --------------------

    always_ff @(posedge CLK) begin
        if (ctrl.init_best) begin
            best_tune <= tune_bits;
            best_cost <= ana_q;
        end else if (ctrl.move_center) begin
            best_tune <= win_tune;
            best_cost <= win_cost;
        end
    end

    // --------------------
    // round winner
    // --------------------

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            win_valid <= 1'b0;
        end else if (ctrl.init_best || ctrl.move_center) begin
            win_valid <= 1'b0;
        end else if (ctrl.record_nbr && better) begin
            win_valid <= 1'b1;
        end
    end

    // ties keep the earlier, lower index
    always_ff @(posedge CLK) begin
        if (ctrl.record_nbr && better) begin
            win_tune <= tune_bits;
            win_cost <= ana_q;
        end
    end

    assign found_local_min = win_valid;

endmodule

//--- search/ss_ctrl_fsm.sv
// sensitivity search control FSM
`timescale 1ns/1ns

module ss_ctrl_fsm (
    input  logic               CLK,
    input  logic               RST_N,
    input  logic               start,
    input  logic               nxt,
    input  ss_pkg::ss_status_t status,
    output ss_pkg::ss_ctrl_t   ctrl,
    output logic               tune_ready,
    output logic               done
);

    ss_pkg::ss_state_e state;
    ss_pkg::ss_state_e next_state;

    // set until the start point has been measured
    logic first_meas;

    // --------------------
    // state register
    // --------------------

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state <= ss_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // initial path vs neighbour path
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            first_meas <= 1'b0;
        end else if (ctrl.load_start) begin
            first_meas <= 1'b1;
        end else if (ctrl.init_best) begin
            first_meas <= 1'b0;
        end
    end

    // --------------------
    // next state and strobes
    // --------------------

    always_comb begin
        next_state = state;
        ctrl       = '0;
        ctrl.busy  = (state != ss_pkg::IDLE) && (state != ss_pkg::DONE);

        case (state)
            ss_pkg::IDLE, ss_pkg::DONE: begin
                if (start) begin
                    ctrl.load_start = 1'b1;
                    next_state      = ss_pkg::REQUEST_INIT;
                end
            end
            ss_pkg::REQUEST_INIT: begin
                // measure the start point itself
                ctrl.req_tune = 1'b1;
                next_state    = ss_pkg::WAIT_CF;
            end
            ss_pkg::ACTIVATE_SS: begin
                ctrl.req_tune = 1'b1;
                next_state    = ss_pkg::WAIT_CF;
            end
            ss_pkg::WAIT_CF: begin
                // analog side may take any number of cycles
                if (nxt) begin
                    next_state = ss_pkg::RECEIVE;
                end
            end
            ss_pkg::RECEIVE: begin
                if (first_meas) begin
                    ctrl.init_best = 1'b1;
                end else begin
                    ctrl.record_nbr = 1'b1;
                    ctrl.inc_cnt    = 1'b1;
                end
                next_state = ss_pkg::JUDGE_NEXT;
            end
            ss_pkg::JUDGE_NEXT: begin
                // budget first, then end of round
                if (status.reach_max_iter) begin
                    next_state = ss_pkg::DONE;
                end else if (status.chk_all_neighbor) begin
                    next_state = ss_pkg::IMPROVEMENT;
                end else begin
                    next_state = ss_pkg::ACTIVATE_SS;
                end
            end
            ss_pkg::IMPROVEMENT: begin
                if (status.found_local_min) begin
                    // recentre on the round winner and start a new round
                    ctrl.move_center = 1'b1;
                    ctrl.rst_round   = 1'b1;
                    next_state       = ss_pkg::JUDGE_NEXT;
                end else begin
                    next_state = ss_pkg::DONE;
                end
            end
            default: begin
                next_state = ss_pkg::IDLE;
            end
        endcase
    end

    // --------------------
    // analog request
    // --------------------

    // one cycle pulse, lines up with the loaded tune_bits
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            tune_ready <= 1'b0;
        end else begin
            tune_ready <= ctrl.req_tune;
        end
    end

    // stays up until the next start
    assign done = (state == ss_pkg::DONE);

endmodule

//--- search/ss_iter_counter.sv
// evaluation and neighbour counters
`timescale 1ns/1ns

module ss_iter_counter (
    input  logic                          CLK,
    input  logic                          RST_N,
    input  ss_pkg::ss_ctrl_t              ctrl,
    input  logic [ss_pkg::ITER_WIDTH-1:0] max_iter,
    output logic [ss_pkg::NBR_WIDTH-1:0]  nbr_idx,
    output logic [ss_pkg::ITER_WIDTH-1:0] eval_cnt,
    output logic                          reach_max_iter,
    output logic                          chk_all_neighbor
);

    // budget captured at start
    logic [ss_pkg::ITER_WIDTH-1:0] max_iter_q;

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            max_iter_q <= '0;
        end else if (ctrl.load_start) begin
            max_iter_q <= max_iter;
        end
    end

    // --------------------
    // counts
    // --------------------

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            eval_cnt <= '0;
            nbr_idx  <= '0;
        end else if (ctrl.load_start) begin
            eval_cnt <= '0;
            nbr_idx  <= '0;
        end else if (ctrl.inc_cnt && ctrl.busy) begin
            // one neighbour measured
            eval_cnt <= eval_cnt + 1'b1;
            nbr_idx  <= nbr_idx + 1'b1;
        end else if (ctrl.rst_round) begin
            nbr_idx <= '0;
        end
    end

    // limit flags straight from the registers
    assign reach_max_iter   = (eval_cnt == max_iter_q);
    assign chk_all_neighbor = (int'(nbr_idx) == 2 * ss_pkg::VAR_NUM);

endmodule

//--- search/ss_neighbor_gen.sv
// centre register and neighbour generation
`timescale 1ns/1ns

module ss_neighbor_gen (
    input  logic                         CLK,
    input  logic                         RST_N,
    input  ss_pkg::ss_ctrl_t             ctrl,
    input  ss_pkg::tune_word_t           init_tune,
    input  logic [ss_pkg::NBR_WIDTH-1:0] nbr_idx,
    input  ss_pkg::tune_word_t           win_tune,
    output ss_pkg::tune_word_t           tune_bits
);

    ss_pkg::tune_word_t center;
    ss_pkg::tune_word_t cand;

    // start point not yet sent out
    logic init_pend;

    // field under test is index / 2
    logic [ss_pkg::NBR_WIDTH-2:0] fsel;

    always_ff @(posedge CLK) begin
        if (ctrl.load_start) begin
            center <= init_tune;
        end else if (ctrl.move_center) begin
            center <= win_tune;
        end
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            init_pend <= 1'b0;
        end else if (ctrl.load_start) begin
            init_pend <= 1'b1;
        end else if (ctrl.req_tune) begin
            init_pend <= 1'b0;
        end
    end

    // --------------------
    // candidate word
    // --------------------

    assign fsel = nbr_idx[ss_pkg::NBR_WIDTH-1:1];

    // even index steps up, odd steps down, saturated fields stay put
    always_comb begin
        cand = center;
        for (int i = 0; i < ss_pkg::VAR_NUM; i++) begin
            if (i == int'(fsel)) begin
                if (!nbr_idx[0] && (center.field[i] != ss_pkg::FIELD_MAX)) begin
                    cand.field[i] = center.field[i] + 1'b1;
                end else if (nbr_idx[0] && (center.field[i] != '0)) begin
                    cand.field[i] = center.field[i] - 1'b1;
                end
            end
        end
    end

    // held through WAIT_CF and RECEIVE
    always_ff @(posedge CLK) begin
        if (ctrl.req_tune) begin
            tune_bits <= init_pend ? center : cand;
        end
    end

endmodule

//--- test/ss_stimulus.txt
// init_tune max_iter target_f3 target_f2 target_f1 target_f0 best_tune best_cost eval_cnt
// all hex, one search per line
0000 100 1 2 0 3 1203 00 038
ffff 100 e f d f efdf 00 020
5555 014 5 a 5 0 5553 08 014
8421 010 7 4 3 1 8431 01 010
0f0f 000 0 0 0 0 0f0f 1e 000
3c7a 7ff 3 c 7 a 3c7a 00 008

//--- test/ss_tuner_tb.sv
// sensitivity search tuner testbench
`timescale 1ns/1ns

module ss_tuner_tb;

    localparam int CASE_NUM = 6;
    localparam int COLS     = 9;

    logic                          CLK = 1'b0;
    logic                          RST_N;
    logic                          start;
    ss_pkg::tune_word_t            init_tune;
    logic [ss_pkg::ITER_WIDTH-1:0] max_iter;
    logic                          tune_ready;
    ss_pkg::tune_word_t            tune_bits;
    logic                          nxt;
    ss_pkg::ana_t                  ana_val;
    logic                          done;
    ss_pkg::tune_word_t            best_tune;
    ss_pkg::ana_t                  best_cost;
    logic [ss_pkg::ITER_WIDTH-1:0] eval_cnt;

    logic [15:0]        stim_mem [0:CASE_NUM*COLS-1];
    ss_pkg::tune_word_t target;
    int                 case_num;
    int                 wd_cycles;
    logic               stim_loaded;

    // reference search, updated only by the analog model
    ss_pkg::tune_word_t center;
    ss_pkg::tune_word_t ref_win;
    ss_pkg::ana_t       ref_best;
    ss_pkg::ana_t       ref_win_cost;
    ss_pkg::ana_t       reply_cost;
    logic               ref_win_valid;
    logic               ref_over;
    int                 ref_idx;
    int                 case_seen;
    int                 req_count;
    int                 wait_cycles;
    logic [31:0]        rng_state;

    ss_tuner_top ss_tuner_top_inst (.*);

    always #2 CLK = ~CLK;

    // --------------------
    // helpers
    // --------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // L1 distance to the target fields
    function automatic ss_pkg::ana_t model_cost(input ss_pkg::tune_word_t t,
                                                input ss_pkg::tune_word_t goal);
        ss_pkg::ana_t sum;
        sum = '0;
        for (int k = 0; k < ss_pkg::VAR_NUM; k++) begin
            if (t.field[2'(k)] > goal.field[2'(k)]) begin
                sum = sum + ss_pkg::ana_t'(t.field[2'(k)] - goal.field[2'(k)]);
            end else begin
                sum = sum + ss_pkg::ana_t'(goal.field[2'(k)] - t.field[2'(k)]);
            end
        end
        return sum;
    endfunction

    // even index one up, odd index one down, held at the field limits
    function automatic ss_pkg::tune_word_t step_neighbour(input ss_pkg::tune_word_t c,
                                                          input int idx);
        ss_pkg::tune_word_t n;
        logic [1:0]         f;
        n = c;
        f = 2'(idx / 2);
        if ((idx % 2) == 0) begin
            if (c.field[f] != ss_pkg::FIELD_MAX) begin
                n.field[f] = c.field[f] + 4'd1;
            end
        end else if (c.field[f] != 4'd0) begin
            n.field[f] = c.field[f] - 4'd1;
        end
        return n;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_quiet;
        check_value("tune_ready", 32'(tune_ready), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("eval_cnt", 32'(eval_cnt), 32'd0);
    endtask

    // predict the requested word, then fold its cost into the reference search
    task automatic track_request;
        ss_pkg::tune_word_t expect_tune;
        logic               first;
        first = (case_seen != case_num);
        if (ref_over && !first) begin
            fail_run("ERROR: tune_ready raised after the search reached a local minimum");
        end
        if (first) begin
            case_seen     = case_num;
            center        = init_tune;
            ref_idx       = 0;
            ref_win_valid = 1'b0;
            ref_over      = 1'b0;
            req_count     = 0;
            expect_tune   = init_tune;
        end else begin
            expect_tune = step_neighbour(center, ref_idx);
        end
        req_count = req_count + 1;
        check_value("tune_bits", 32'(tune_bits.flat), 32'(expect_tune.flat));
        reply_cost = model_cost(tune_bits, target);
        if (first) begin
            ref_best = reply_cost;
        end else begin
            if ((reply_cost < ref_best) && (!ref_win_valid || (reply_cost < ref_win_cost))) begin
                ref_win       = tune_bits;
                ref_win_cost  = reply_cost;
                ref_win_valid = 1'b1;
            end
            ref_idx = ref_idx + 1;
            if (ref_idx == 2 * ss_pkg::VAR_NUM) begin
                if (ref_win_valid) begin
                    center        = ref_win;
                    ref_best      = ref_win_cost;
                    ref_win_valid = 1'b0;
                    ref_idx       = 0;
                end else begin
                    ref_over = 1'b1;
                end
            end
        end
    endtask

    task automatic run_search(input int c);
        int base;
        base            = c * COLS;
        init_tune.flat  = stim_mem[base];
        max_iter        = stim_mem[base + 1][ss_pkg::ITER_WIDTH-1:0];
        target.field[3] = stim_mem[base + 2][3:0];
        target.field[2] = stim_mem[base + 3][3:0];
        target.field[1] = stim_mem[base + 4][3:0];
        target.field[0] = stim_mem[base + 5][3:0];
        case_num        = c + 1;
        start           = 1'b1;
        @(negedge CLK);
        start = 1'b0;
        check_value("done", 32'(done), 32'd0);
        while (done !== 1'b1) begin
            @(negedge CLK);
        end
        check_value("best_tune", 32'(best_tune.flat), 32'(stim_mem[base + 6]));
        check_value("best_cost", 32'(best_cost), 32'(stim_mem[base + 7]));
        check_value("eval_cnt", 32'(eval_cnt), 32'(stim_mem[base + 8]));
        check_value("best_cost model", 32'(best_cost), 32'(model_cost(best_tune, target)));
        check_value("tune_ready count", 32'(req_count), 32'(stim_mem[base + 8]) + 32'd1);
    endtask

    // --------------------
    // analog circuit model
    // --------------------

    initial begin
        nxt         = 1'b0;
        ana_val     = '0;
        rng_state   = 32'hf0bb_c6fd;
        wait_cycles = 0;
        case_seen   = 0;
        forever begin
            @(negedge CLK);
            nxt = 1'b0;
            if (tune_ready && (wait_cycles > 0)) begin
                fail_run("ERROR: tune_ready raised while a measurement was pending");
            end else if (wait_cycles > 0) begin
                wait_cycles = wait_cycles - 1;
                if (wait_cycles == 0) begin
                    nxt     = 1'b1;
                    ana_val = reply_cost;
                end
            end else if (tune_ready) begin
                track_request();
                rng_state   = lcg_next(rng_state);
                wait_cycles = 1 + int'(rng_state[23:16]) % 6;
            end else if (RST_N) begin
                // stray answer with the cheapest possible cost
                rng_state = lcg_next(rng_state);
                if (rng_state[31:29] == 3'd0) begin
                    nxt     = 1'b1;
                    ana_val = '0;
                end
            end
        end
    end

    // --------------------
    // main sequence
    // --------------------

    initial begin
        RST_N       = 1'b0;
        start       = 1'b0;
        init_tune   = '0;
        max_iter    = '0;
        target      = '0;
        case_num    = 0;
        stim_loaded = 1'b0;
        for (int i = 0; i < CASE_NUM * COLS; i++) begin
            stim_mem[i] = ~16'(i);
        end
        $readmemh("test/ss_stimulus.txt", stim_mem);
        wd_cycles = 500;
        for (int c = 0; c < CASE_NUM; c++) begin
            if (stim_mem[c * COLS + 1] > 16'h07ff) begin
                fail_run("ERROR: stimulus file is missing or malformed");
            end
            wd_cycles = wd_cycles + 64 * (int'(stim_mem[c * COLS + 1]) + 1);
        end
        stim_loaded = 1'b1;

        // outputs stay quiet through reset
        repeat (8) begin
            @(negedge CLK);
            check_quiet();
        end
        RST_N = 1'b1;
        @(negedge CLK);
        check_quiet();

        for (int c = 0; c < CASE_NUM; c++) begin
            run_search(c);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    // budget of 64 cycles per evaluation
    initial begin
        wait (stim_loaded === 1'b1);
        repeat (wd_cycles) @(posedge CLK);
        fail_run("ERROR: watchdog expired, the search never finished");
    end

endmodule

//--- verilog.f
common/ss_pkg.sv
search/ss_ctrl_fsm.sv
search/ss_iter_counter.sv
search/ss_neighbor_gen.sv
search/ss_best_tracker.sv
logic/ss_tuner_top.sv
test/ss_tuner_tb.sv
